//--- hdl/bus_pkg.sv
// bus widths are fixed here; every slave depth must be a power of two no larger than 2**ADDR_W
package bus_pkg;

	localparam int ADDR_W   = 12;
	localparam int DATA_W   = 8;
	localparam int BURST_W  = 4;
	localparam int SEL_W    = 2;
	localparam int N_SLAVES = 3;

	// header on the wire is address then burst count, lsb first
	localparam int HDR_W = ADDR_W + BURST_W;

	typedef logic [ADDR_W-1:0]  addr_t;  // byte address
	typedef logic [DATA_W-1:0]  data_t;  // one byte
	typedef logic [BURST_W-1:0] burst_t; // beats 1..15, 0 is illegal
	typedef logic [SEL_W-1:0]   sel_t;   // slave 0..2, 3 is illegal

endpackage

//--- hdl/link_pkg.sv
// link structs carry one serial bit per direction; the field order is the packed layout
package link_pkg;

	// one master command, loaded on a start pulse
	typedef struct packed {
		logic            write;  // 1 write, 0 read
		bus_pkg::addr_t  addr;
		bus_pkg::data_t  data;   // same byte stored on every write beat
		bus_pkg::sel_t   sel;
		bus_pkg::burst_t burst;
	} cmd_t;

	typedef struct packed {
		logic          req;
		bus_pkg::sel_t sel;  // target slave of the bid
	} arb_req_t;

	// toward the slave
	typedef struct packed {
		logic master_valid;
		logic master_ready;
		logic write_en;
		logic read_en;
		logic tx_bit;
	} m2s_t;

	// back to the master
	typedef struct packed {
		logic slave_valid;
		logic slave_ready;
		logic rx_bit;
	} s2m_t;

endpackage

//--- hdl/bus_master.sv
// one command at a time; starts while busy are dropped, burst 0 and slave 3 are illegal
`timescale 1ns/10ps

module bus_master (
	input  logic               clk,
	input  logic               rst_n,
	input  link_pkg::cmd_t     cmd,
	input  logic               start,
	output logic               busy,
	output bus_pkg::data_t     rdata,
	output logic               rvalid,
	output link_pkg::arb_req_t req,
	input  logic               grant,
	output logic               done,
	output link_pkg::m2s_t     m2s,
	input  link_pkg::s2m_t     s2m
);
	import bus_pkg::*;
	import link_pkg::*;

	localparam int CNT_W = $clog2(HDR_W);

	typedef enum logic [2:0] {
		M_IDLE,
		M_REQUEST,
		M_HEADER,
		M_WDATA,
		M_RDATA,
		M_FINISH
	} state_t;

	state_t             state;
	cmd_t               cmd_q;
	logic [HDR_W-1:0]   tx_sh;   // header first, then one data byte per beat
	logic [DATA_W-2:0]  rx_sh;
	data_t              rx_byte;
	logic [CNT_W-1:0]   bit_cnt;
	burst_t             beat_cnt;
	logic               in_xfer;
	logic               tx_fire;
	logic               rx_fire;
	logic               hdr_last;
	logic               last_bit;
	logic               last_beat;

	assign in_xfer   = (state == M_HEADER) || (state == M_WDATA) || (state == M_RDATA);
	assign tx_fire   = m2s.master_valid && s2m.slave_ready;
	assign rx_fire   = s2m.slave_valid && m2s.master_ready;
	assign hdr_last  = (bit_cnt == CNT_W'(HDR_W - 1));
	assign last_bit  = (bit_cnt == CNT_W'(DATA_W - 1));
	assign last_beat = (beat_cnt == cmd_q.burst - 1'b1);
	assign rx_byte   = {s2m.rx_bit, rx_sh};

	assign busy    = (state != M_IDLE);
	assign done    = (state == M_FINISH);
	assign req.req = (state == M_REQUEST);
	assign req.sel = cmd_q.sel;

	always_comb begin
		m2s              = '0;
		m2s.master_valid = (state == M_HEADER) || (state == M_WDATA);
		m2s.master_ready = (state == M_RDATA); // always ready for read bits
		m2s.write_en     = in_xfer && cmd_q.write;
		m2s.read_en      = in_xfer && !cmd_q.write;
		m2s.tx_bit       = tx_sh[0];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= M_IDLE;
			bit_cnt  <= '0;
			beat_cnt <= '0;
			rvalid   <= 1'b0;
		end else begin
			rvalid <= 1'b0;
			case (state)
				M_IDLE: if (start) state <= M_REQUEST;
				M_REQUEST: if (grant) begin
					state   <= M_HEADER;
					bit_cnt <= '0;
				end
				M_HEADER: if (tx_fire) begin
					bit_cnt <= bit_cnt + 1'b1;
					if (hdr_last) begin
						bit_cnt  <= '0;
						beat_cnt <= '0;
						state    <= cmd_q.write ? M_WDATA : M_RDATA;
					end
				end
				M_WDATA, M_RDATA: if ((state == M_WDATA) ? tx_fire : rx_fire) begin
					bit_cnt <= bit_cnt + 1'b1;
					if (last_bit) begin
						bit_cnt  <= '0;
						beat_cnt <= beat_cnt + 1'b1;
						rvalid   <= (state == M_RDATA); // byte lands in rdata this edge
						if (last_beat) state <= M_FINISH;
					end
				end
				M_FINISH: state <= M_IDLE;
				default: state <= M_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == M_IDLE && start) begin
			cmd_q <= cmd;
			tx_sh <= {cmd.burst, cmd.addr};
		end else if (tx_fire) begin
			if ((state == M_HEADER && hdr_last) || (state == M_WDATA && last_bit))
				tx_sh <= HDR_W'(cmd_q.data); // reload for the next beat
			else
				tx_sh <= tx_sh >> 1;
		end
		if (rx_fire) begin
			rx_sh <= rx_byte[DATA_W-1:1];
			if (last_bit) rdata <= rx_byte;
		end
	end

	a_burst_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		(start && !busy) |-> (cmd.burst != '0));

	a_sel_legal: assert property (@(posedge clk) disable iff (!rst_n)
		(start && !busy) |-> (cmd.sel < sel_t'(N_SLAVES)));

endmodule

//--- hdl/bus_arbiter.sv
// master 0 always wins a tie; an owner keeps the bus until its done pulse, with no timeout
`timescale 1ns/10ps

module bus_arbiter (
	input  logic               clk,
	input  logic               rst_n,
	input  link_pkg::arb_req_t req0,
	input  link_pkg::arb_req_t req1,
	input  logic               done0,
	input  logic               done1,
	output logic               grant0,
	output logic               grant1
);

	typedef enum logic [1:0] {
		A_FREE,
		A_OWN0,
		A_OWN1
	} state_t;

	state_t state;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= A_FREE;
		end else begin
			case (state)
				A_FREE: begin
					if (req0.req)      state <= A_OWN0; // fixed priority
					else if (req1.req) state <= A_OWN1;
				end
				A_OWN0: if (done0) state <= A_FREE;
				A_OWN1: if (done1) state <= A_FREE;
				default: state <= A_FREE;
			endcase
		end
	end

	assign grant0 = (state == A_OWN0);
	assign grant1 = (state == A_OWN1);

	a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
		!(grant0 && grant1));

endmodule

//--- hdl/bus_interconnect.sv
// pure routing around the arbiter; the owner's sel is frozen for the whole transaction
`timescale 1ns/10ps

module bus_interconnect (
	input  logic               clk,
	input  logic               rst_n,
	input  link_pkg::arb_req_t req0,
	input  link_pkg::arb_req_t req1,
	input  logic               done0,
	input  logic               done1,
	output logic               grant0,
	output logic               grant1,
	input  link_pkg::m2s_t     m2s0,
	input  link_pkg::m2s_t     m2s1,
	output link_pkg::s2m_t     s2m0,
	output link_pkg::s2m_t     s2m1,
	output link_pkg::m2s_t     sm2s [bus_pkg::N_SLAVES],
	input  link_pkg::s2m_t     ss2m [bus_pkg::N_SLAVES]
);
	import bus_pkg::*;
	import link_pkg::*;

	sel_t sel_q;
	m2s_t m2s_own;
	s2m_t s2m_sel;
	logic any_grant;

	bus_arbiter arbiter (
		.clk    (clk),
		.rst_n  (rst_n),
		.req0   (req0),
		.req1   (req1),
		.done0  (done0),
		.done1  (done1),
		.grant0 (grant0),
		.grant1 (grant1)
	);

	// same priority as the arbiter, captured on the edge the grant goes out
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sel_q <= '0;
		end else if (!grant0 && !grant1) begin
			if (req0.req)      sel_q <= req0.sel;
			else if (req1.req) sel_q <= req1.sel;
		end
	end

	assign any_grant = grant0 || grant1;
	assign m2s_own   = grant0 ? m2s0 : m2s1;

	always_comb begin
		s2m_sel = '0;
		for (int i = 0; i < N_SLAVES; i++) begin
			sm2s[i] = '0; // unselected slaves stay idle
			if (any_grant && sel_q == sel_t'(i)) begin
				sm2s[i] = m2s_own;
				s2m_sel = ss2m[i];
			end
		end
	end

	always_comb begin
		s2m0 = '0;
		s2m1 = '0;
		if (grant0) s2m0 = s2m_sel;
		if (grant1) s2m1 = s2m_sel;
	end

endmodule

//--- hdl/bus_slave.sv
// MEM_DEPTH must be a power of two; addresses wrap modulo the depth and memory is not cleared by reset
`timescale 1ns/10ps

module bus_slave #(
	parameter int MEM_DEPTH   = 4096,
	parameter int SLAVE_DELAY = 0
) (
	input  logic           clk,
	input  logic           rst_n,
	input  link_pkg::m2s_t m2s,
	output link_pkg::s2m_t s2m
);
	import bus_pkg::*;

	localparam int HCNT_W = $clog2(HDR_W);
	localparam int BCNT_W = $clog2(DATA_W);
	localparam int IDX_W  = $clog2(MEM_DEPTH);
	localparam int DLY_W  = $clog2(SLAVE_DELAY + 2);

	typedef enum logic [2:0] {
		S_IDLE,
		S_HEADER,
		S_WBEAT,
		S_DELAY,
		S_RBEAT
	} state_t;

	state_t             state;
	data_t              mem [MEM_DEPTH];
	logic [HDR_W-2:0]   hdr_sh;
	logic [HDR_W-1:0]   hdr_next;
	logic [DATA_W-2:0]  wr_sh;
	data_t              wr_byte;
	data_t              rd_sh;
	addr_t              addr_q;
	addr_t              rd_addr;
	burst_t             burst_q;
	burst_t             beat_cnt;
	logic [HCNT_W-1:0]  hdr_cnt;
	logic [BCNT_W-1:0]  bit_cnt;
	logic [DLY_W-1:0]   dly_cnt;
	logic               rx_fire;
	logic               tx_fire;
	logic               last_bit;
	logic               last_beat;
	logic               hdr_done;
	logic               wbeat_done;
	logic               rbeat_done;

	always_comb begin
		s2m             = '0;
		s2m.slave_ready = (state == S_IDLE) || (state == S_HEADER) || (state == S_WBEAT);
		s2m.slave_valid = (state == S_RBEAT);
		s2m.rx_bit      = rd_sh[0];
	end

	assign rx_fire    = m2s.master_valid && s2m.slave_ready;
	assign tx_fire    = s2m.slave_valid && m2s.master_ready;
	assign hdr_next   = {m2s.tx_bit, hdr_sh};
	assign wr_byte    = {m2s.tx_bit, wr_sh};
	assign last_bit   = (bit_cnt == BCNT_W'(DATA_W - 1));
	assign last_beat  = (beat_cnt == burst_q - 1'b1);
	assign hdr_done   = (state == S_IDLE || state == S_HEADER) && rx_fire &&
	                    (hdr_cnt == HCNT_W'(HDR_W - 1));
	assign wbeat_done = (state == S_WBEAT) && rx_fire && last_bit;
	assign rbeat_done = (state == S_RBEAT) && tx_fire && last_bit;
	// next byte to fetch: header address on the first beat, else the one after
	assign rd_addr    = (state == S_RBEAT) ? addr_q + 1'b1 : hdr_next[ADDR_W-1:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= S_IDLE;
			hdr_cnt  <= '0;
			bit_cnt  <= '0;
			beat_cnt <= '0;
			dly_cnt  <= '0;
		end else begin
			case (state)
				S_IDLE, S_HEADER: if (rx_fire) begin // first header bit may come in idle
					hdr_cnt <= hdr_cnt + 1'b1;
					state   <= S_HEADER;
					if (hdr_done) begin
						hdr_cnt  <= '0;
						bit_cnt  <= '0;
						beat_cnt <= '0;
						dly_cnt  <= '0;
						if (m2s.write_en) state <= S_WBEAT;
						else state <= (SLAVE_DELAY > 0) ? S_DELAY : S_RBEAT;
					end
				end
				S_WBEAT: if (rx_fire) begin
					bit_cnt <= bit_cnt + 1'b1;
					if (last_bit) begin
						bit_cnt  <= '0;
						beat_cnt <= beat_cnt + 1'b1;
						if (last_beat) state <= S_IDLE;
					end
				end
				S_DELAY: begin
					dly_cnt <= dly_cnt + 1'b1;
					if (dly_cnt == DLY_W'(SLAVE_DELAY - 1)) begin
						dly_cnt <= '0;
						state   <= S_RBEAT;
					end
				end
				S_RBEAT: if (tx_fire) begin
					bit_cnt <= bit_cnt + 1'b1;
					if (last_bit) begin
						bit_cnt  <= '0;
						beat_cnt <= beat_cnt + 1'b1;
						if (last_beat) state <= S_IDLE;
						else state <= (SLAVE_DELAY > 0) ? S_DELAY : S_RBEAT; // delay every beat
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rx_fire) begin
			hdr_sh <= hdr_next[HDR_W-1:1];
			wr_sh  <= wr_byte[DATA_W-1:1];
		end
		if (hdr_done) begin
			addr_q  <= hdr_next[ADDR_W-1:0];
			burst_q <= hdr_next[HDR_W-1:ADDR_W];
		end
		if (wbeat_done) begin
			mem[addr_q[IDX_W-1:0]] <= wr_byte;
			addr_q                 <= addr_q + 1'b1;
		end
		if (rbeat_done) addr_q <= addr_q + 1'b1;
		if ((hdr_done && m2s.read_en) || rbeat_done)
			rd_sh <= mem[rd_addr[IDX_W-1:0]];
		else if (tx_fire)
			rd_sh <= rd_sh >> 1; // lsb goes out first
	end

	a_one_dir: assert property (@(posedge clk) disable iff (!rst_n)
		!(m2s.write_en && m2s.read_en));

endmodule

//--- hdl/serial_bus_top.sv
// single clock domain; slaves hold 4096, 2048 and 2048 bytes, slave 2 adds 10 cycles per read beat
`timescale 1ns/10ps

module serial_bus_top (
	input  logic           clk,
	input  logic           rst_n,
	input  link_pkg::cmd_t cmd0,
	input  link_pkg::cmd_t cmd1,
	input  logic           start0,
	input  logic           start1,
	output logic           busy0,
	output logic           busy1,
	output bus_pkg::data_t rdata0,
	output bus_pkg::data_t rdata1,
	output logic           rvalid0,
	output logic           rvalid1
);
	import bus_pkg::*;
	import link_pkg::*;

	arb_req_t req0;
	arb_req_t req1;
	logic     grant0;
	logic     grant1;
	logic     done0;
	logic     done1;
	m2s_t     m2s0;
	m2s_t     m2s1;
	s2m_t     s2m0;
	s2m_t     s2m1;
	m2s_t     sm2s [N_SLAVES];
	s2m_t     ss2m [N_SLAVES];

	bus_master master0 (
		.clk (clk), .rst_n (rst_n), .cmd (cmd0), .start (start0), .busy (busy0),
		.rdata (rdata0), .rvalid (rvalid0), .req (req0), .grant (grant0), .done (done0),
		.m2s (m2s0), .s2m (s2m0)
	);

	bus_master master1 (
		.clk (clk), .rst_n (rst_n), .cmd (cmd1), .start (start1), .busy (busy1),
		.rdata (rdata1), .rvalid (rvalid1), .req (req1), .grant (grant1), .done (done1),
		.m2s (m2s1), .s2m (s2m1)
	);

	bus_interconnect bus (
		.clk (clk), .rst_n (rst_n), .req0 (req0), .req1 (req1), .done0 (done0),
		.done1 (done1), .grant0 (grant0), .grant1 (grant1), .m2s0 (m2s0), .m2s1 (m2s1),
		.s2m0 (s2m0), .s2m1 (s2m1), .sm2s (sm2s), .ss2m (ss2m)
	);

	bus_slave #(.MEM_DEPTH(4096), .SLAVE_DELAY(0)) slave_4k (
		.clk (clk), .rst_n (rst_n), .m2s (sm2s[0]), .s2m (ss2m[0])
	);

	bus_slave #(.MEM_DEPTH(2048), .SLAVE_DELAY(0)) slave_2k1 (
		.clk (clk), .rst_n (rst_n), .m2s (sm2s[1]), .s2m (ss2m[1])
	);

	// slow slave
	bus_slave #(.MEM_DEPTH(2048), .SLAVE_DELAY(10)) slave_2k2 (
		.clk (clk), .rst_n (rst_n), .m2s (sm2s[2]), .s2m (ss2m[2])
	);

endmodule

//--- sim/serial_bus_tb.sv
// random stimulus with a fixed seed; every read covers bytes this testbench wrote before
`timescale 1ns/10ps

module serial_bus_tb;
	import bus_pkg::*;
	import link_pkg::*;

	localparam int N_RAND     = 8;   // write and read pairs per master
	localparam int N_CMDS     = 50;  // all commands of all tests
	localparam int SLOW_DELAY = 10;  // read delay of slave 2
	localparam int WORST_CYC  = HDR_W + 15 * (DATA_W + SLOW_DELAY);
	localparam int TIMEOUT_NS = (16 + N_CMDS * 2 * WORST_CYC) * 10;

	logic  clk;
	logic  rst_n;
	cmd_t  cmd0;
	cmd_t  cmd1;
	logic  start0;
	logic  start1;
	logic  busy0;
	logic  busy1;
	data_t rdata0;
	data_t rdata1;
	logic  rvalid0;
	logic  rvalid1;

	data_t model [N_SLAVES][4096]; // mirror of the three slave memories
	data_t q0 [$];                 // read bytes still owed to master 0
	data_t q1 [$];
	data_t head0;
	data_t head1;
	int    exp_cnt0;
	int    exp_cnt1;
	logic  seen0;
	logic  seen1;
	logic  started;
	int    seed;
	string test_name;

	serial_bus_top UUT (
		.clk (clk), .rst_n (rst_n), .cmd0 (cmd0), .cmd1 (cmd1), .start0 (start0),
		.start1 (start1), .busy0 (busy0), .busy1 (busy1), .rdata0 (rdata0),
		.rdata1 (rdata1), .rvalid0 (rvalid0), .rvalid1 (rvalid1)
	);

	always #5 clk = ~clk;

	task automatic stop_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic value_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("error %s expected %0h actual %0h", name, exp, act);
		stop_run();
	endtask

	task automatic fail_with_reason(input string what);
		$display("%s", what);
		stop_run();
	endtask

	function automatic int depth_of(input sel_t sel);
		return (sel == 2'd0) ? 4096 : 2048;
	endfunction

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic busy_of(input int m);
		return (m == 0) ? busy0 : busy1;
	endfunction

	function automatic cmd_t make_cmd(input logic wr, input int addr, input int data,
		input int sel, input int burst);
		cmd_t c;
		c.write = wr;
		c.addr  = addr_t'(addr);
		c.data  = data_t'(data);
		c.sel   = sel_t'(sel);
		c.burst = burst_t'(burst);
		return c;
	endfunction

	task automatic refresh_heads();
		exp_cnt0 = q0.size();
		exp_cnt1 = q1.size();
		head0    = (exp_cnt0 != 0) ? q0[0] : '0;
		head1    = (exp_cnt1 != 0) ? q1[0] : '0;
	endtask

	task automatic wait_idle(input int m);
		@(negedge clk);
		while (busy_of(m)) @(negedge clk);
	endtask

	// issue one command, update the model, wait until busy falls
	task automatic run_cmd(input int m, input cmd_t c, output int cycles);
		int i;
		int idx;
		int depth;
		depth = depth_of(c.sel);
		wait_idle(m);
		@(posedge clk);
		if (m == 0) begin
			cmd0   <= c;
			start0 <= 1'b1;
		end else begin
			cmd1   <= c;
			start1 <= 1'b1;
		end
		started = 1'b1;
		for (i = 0; i < int'(c.burst); i++) begin
			idx = (int'(c.addr) + i) % depth; // wraps at the slave depth
			if (c.write) model[c.sel][idx] = c.data;
			else if (m == 0) q0.push_back(model[c.sel][idx]);
			else q1.push_back(model[c.sel][idx]);
		end
		refresh_heads();
		@(posedge clk);
		if (m == 0) start0 <= 1'b0;
		else start1 <= 1'b0;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (busy_of(m));
	endtask

	task automatic random_traffic(input int m, input int base);
		int n;
		int s;
		int a;
		int b;
		int d;
		int cycles;
		for (n = 0; n < N_RAND; n++) begin
			s = rand_below(N_SLAVES);
			a = base + rand_below(1000); // stays inside this master's 1k window
			b = 1 + rand_below(15);
			d = rand_below(256);
			run_cmd(m, make_cmd(1'b1, a, d, s, b), cycles);
			run_cmd(m, make_cmd(1'b0, a, 0, s, b), cycles);
		end
	endtask

	// rvalid seen at negedge, popped at the following posedge
	always @(negedge clk) begin
		seen0 <= rvalid0;
		seen1 <= rvalid1;
	end

	always @(posedge clk) begin
		if (seen0 && q0.size() != 0) void'(q0.pop_front());
		if (seen1 && q1.size() != 0) void'(q1.pop_front());
		refresh_heads();
	end

	a_quiet_before_start: assert property (@(negedge clk) disable iff (!rst_n)
		!started |-> !(busy0 || busy1 || rvalid0 || rvalid1))
		else fail_with_reason("busy or rvalid went high before any start pulse");

	a_rvalid0_owed: assert property (@(negedge clk) disable iff (!rst_n)
		rvalid0 |-> (exp_cnt0 != 0))
		else fail_with_reason("master 0 returned a read byte that was never requested");

	a_rvalid1_owed: assert property (@(negedge clk) disable iff (!rst_n)
		rvalid1 |-> (exp_cnt1 != 0))
		else fail_with_reason("master 1 returned a read byte that was never requested");

	a_rdata0: assert property (@(negedge clk) disable iff (!rst_n)
		(rvalid0 && exp_cnt0 != 0) |-> (rdata0 === head0))
		else value_mismatch(test_name, 32'(head0), 32'(rdata0));

	a_rdata1: assert property (@(negedge clk) disable iff (!rst_n)
		(rvalid1 && exp_cnt1 != 0) |-> (rdata1 === head1))
		else value_mismatch(test_name, 32'(head1), 32'(rdata1));

	initial begin
		#(TIMEOUT_NS);
		fail_with_reason("watchdog expired, a transaction never finished");
	end

	initial begin
		int dur0;
		int dur2;
		int d;
		int a;
		int s;
		seed      = 69;
		clk       = 1'b0;
		rst_n     = 1'b0;
		cmd0      = '0;
		cmd1      = '0;
		start0    = 1'b0;
		start1    = 1'b0;
		started   = 1'b0;
		seen0     = 1'b0;
		seen1     = 1'b0;
		test_name = "reset";
		refresh_heads();
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		repeat (5) @(posedge clk); // outputs must stay quiet here

		test_name = "single beat write and read";
		for (s = 0; s < N_SLAVES; s++) begin
			a = rand_below(depth_of(sel_t'(s)));
			d = rand_below(256);
			run_cmd(s % 2, make_cmd(1'b1, a, d, s, 1), dur0);
			run_cmd(s % 2, make_cmd(1'b0, a, 0, s, 1), dur0);
		end

		test_name = "burst wrap and alias";
		d = rand_below(256);
		run_cmd(1, make_cmd(1'b1, 2040, d, 1, 15), dur0);
		run_cmd(1, make_cmd(1'b1, 2046, d ^ 8'h5a, 1, 1), dur0);
		run_cmd(0, make_cmd(1'b1, 2053, d ^ 8'ha5, 1, 1), dur0); // lands on address 5
		run_cmd(1, make_cmd(1'b0, 2040, 0, 1, 15), dur0);
		run_cmd(0, make_cmd(1'b0, 4088, 0, 1, 15), dur0);

		test_name = "two masters random";
		fork
			random_traffic(0, 0);
			random_traffic(1, 1024);
		join

		test_name = "slow slave read";
		run_cmd(0, make_cmd(1'b1, 100, rand_below(256), 0, 4), dur0);
		run_cmd(0, make_cmd(1'b1, 100, rand_below(256), 2, 4), dur0);
		run_cmd(0, make_cmd(1'b0, 100, 0, 0, 4), dur0);
		run_cmd(0, make_cmd(1'b0, 100, 0, 2, 4), dur2);
		a_slow_busy: assert (dur2 >= dur0 + 4 * SLOW_DELAY)
			else value_mismatch(test_name, 32'(dur0 + 4 * SLOW_DELAY), 32'(dur2));

		test_name = "start while busy";
		d = rand_below(256);
		fork
			run_cmd(1, make_cmd(1'b1, 300, d, 1, 1), dur0);
			begin
				do @(negedge clk); while (!busy1);
				repeat (3) @(posedge clk);
				cmd1   <= make_cmd(1'b1, 300, d ^ 8'hff, 1, 1); // must be dropped
				start1 <= 1'b1;
				@(posedge clk);
				start1 <= 1'b0;
			end
		join
		run_cmd(1, make_cmd(1'b0, 300, 0, 1, 1), dur0);

		repeat (20) @(posedge clk);
		if (exp_cnt0 == 0 && exp_cnt1 == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			fail_with_reason("read bytes were still owed when the run ended");
		end
	end

endmodule

//--- serial_bus_top.f
hdl/bus_pkg.sv
hdl/link_pkg.sv
hdl/bus_master.sv
hdl/bus_arbiter.sv
hdl/bus_interconnect.sv
hdl/bus_slave.sv
hdl/serial_bus_top.sv
sim/serial_bus_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module serial_bus_tb \
	-f serial_bus_top.f -o serial_bus_sim

./obj_dir/serial_bus_sim | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
